//--- source/fetchPkg.sv
package fetchPkg;

  localparam int FETCH_WIDTH    = 4;
  localparam int PC_WIDTH       = 32;
  localparam int INST_WIDTH     = 32;
  localparam int CTIQ_DEPTH     = 16;
  localparam int CTIQ_TAG_WIDTH = 4;

  // Opcode lives in instruction bits 31:26
  localparam logic [5:0] OPC_J   = 6'h02;
  localparam logic [5:0] OPC_JAL = 6'h03;
  localparam logic [5:0] OPC_BR  = 6'h04;
  localparam logic [5:0] OPC_JR  = 6'h08;

  typedef logic [1:0] ctrlType_t;

  localparam ctrlType_t CTRL_RTR  = 2'd0;
  localparam ctrlType_t CTRL_CALL = 2'd1;
  localparam ctrlType_t CTRL_JUMP = 2'd2;
  localparam ctrlType_t CTRL_BR   = 2'd3;

  // Per-slot prediction from fetch stage 1
  typedef struct packed {
    logic                btbHit;
    logic [PC_WIDTH-1:0] targetAddr;
    logic                prediction;
  } slotPred_t;

  typedef struct packed {
    logic [INST_WIDTH-1:0]     instruction;
    logic [PC_WIDTH-1:0]       pc;
    logic [PC_WIDTH-1:0]       targetAddr;
    logic [CTIQ_TAG_WIDTH-1:0] ctiqTag;
    logic                      prediction;
  } instPacket_t;

  typedef struct packed {
    logic [CTIQ_TAG_WIDTH-1:0] index;
    logic [PC_WIDTH-1:0]       targetAddr;
    logic                      outcome;
  } exeResolve_t;

  // Also the layout of one queue entry
  typedef struct packed {
    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] targetAddr;
    ctrlType_t           ctrlType;
    logic                dir;
  } ctiUpdate_t;

  typedef struct packed {
    logic                flagRecover;
    logic                flagRtr;
    logic                flagCall;
    logic [PC_WIDTH-1:0] targetAddr;
    logic [PC_WIDTH-1:0] callPC;
  } idRedirect_t;

endpackage

//--- source/PreDecode.sv
module PreDecode
  import fetchPkg::*;
(
  input  logic [INST_WIDTH-1:0] instruction_i,
  input  logic [PC_WIDTH-1:0]   pc_i,
  input  logic [PC_WIDTH-1:0]   btbTarget_i,
  output logic                  isCtrl_o,
  output ctrlType_t             ctrlType_o,
  output logic [PC_WIDTH-1:0]   targetAddr_o
);

  logic [5:0]          opcode;
  logic [PC_WIDTH-1:0] seqPc;
  logic [PC_WIDTH-1:0] branchTarget;
  logic [PC_WIDTH-1:0] jumpTarget;

  assign opcode = instruction_i[31:26];
  assign seqPc  = pc_i + PC_WIDTH'(4);

  // Signed word offset relative to the next instruction
  assign branchTarget = seqPc + {{14{instruction_i[15]}}, instruction_i[15:0], 2'b00};

  // Region-relative absolute target
  assign jumpTarget = {pc_i[PC_WIDTH-1:28], instruction_i[25:0], 2'b00};

  always_comb
  begin
    isCtrl_o     = 1'b1;
    ctrlType_o   = CTRL_RTR;
    targetAddr_o = seqPc;
    case (opcode)
      OPC_JR:
      begin
        ctrlType_o   = CTRL_RTR;
        targetAddr_o = btbTarget_i;
      end
      OPC_JAL:
      begin
        ctrlType_o   = CTRL_CALL;
        targetAddr_o = jumpTarget;
      end
      OPC_J:
      begin
        ctrlType_o   = CTRL_JUMP;
        targetAddr_o = jumpTarget;
      end
      OPC_BR:
      begin
        ctrlType_o   = CTRL_BR;
        targetAddr_o = branchTarget;
      end
      default:
        isCtrl_o = 1'b0;
    endcase
  end

endmodule

//--- source/CtrlQueue.sv
module CtrlQueue
  import fetchPkg::*;
(
  input  logic                                          clk,
  input  logic                                          rst_i,
  input  logic                                          fs1Ready_i,
  input  logic                                          stall_i,
  input  logic                                          recoverFlag_i,
  input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]          slotPc_i,
  input  ctrlType_t [FETCH_WIDTH-1:0]                   slotType_i,
  input  logic [FETCH_WIDTH-1:0]                        ctrlVector_i,
  output logic [FETCH_WIDTH-1:0][CTIQ_TAG_WIDTH-1:0]    ctiqTag_o,
  input  exeResolve_t                                   exeResolve_i,
  input  logic                                          ctrlVerified_i,
  input  logic                                          flagRecoverEX_i,
  input  logic                                          commitCti_i,
  output ctiUpdate_t                                    update_o,
  output logic                                          updateEn_o,
  output logic                                          full_o
);

  ctiUpdate_t ctiq [CTIQ_DEPTH];

  logic [CTIQ_TAG_WIDTH-1:0] head;
  logic [CTIQ_TAG_WIDTH-1:0] tail;
  logic [CTIQ_TAG_WIDTH:0]   count;

  logic [CTIQ_TAG_WIDTH-1:0] tagOffset;
  logic [CTIQ_TAG_WIDTH-1:0] allocCount;
  logic [CTIQ_TAG_WIDTH-1:0] allocNum;
  logic [CTIQ_TAG_WIDTH-1:0] keepDist;
  logic                      allocEn;

  // Consecutive tags for the marked slots, oldest first
  always_comb
  begin
    tagOffset = '0;
    for (int k = 0; k < FETCH_WIDTH; k++)
    begin
      ctiqTag_o[k] = tail + tagOffset;
      tagOffset    = tagOffset + CTIQ_TAG_WIDTH'(ctrlVector_i[k]);
    end
    allocCount = tagOffset;
  end

  assign full_o   = (count > (CTIQ_DEPTH - FETCH_WIDTH));
  assign allocEn  = fs1Ready_i & ~stall_i & ~full_o & ~recoverFlag_i & ~flagRecoverEX_i;
  assign allocNum = allocEn ? allocCount : '0;

  // Entries kept on a mispredict are head up to the resolved index
  assign keepDist = exeResolve_i.index - head;

  always_ff @(posedge clk)
  begin
    if (allocEn)
    begin
      for (int k = 0; k < FETCH_WIDTH; k++)
      begin
        if (ctrlVector_i[k])
        begin
          ctiq[ctiqTag_o[k]].pc       <= slotPc_i[k];
          ctiq[ctiqTag_o[k]].ctrlType <= slotType_i[k];
        end
      end
    end
    if (ctrlVerified_i)
    begin
      ctiq[exeResolve_i.index].targetAddr <= exeResolve_i.targetAddr;
      ctiq[exeResolve_i.index].dir        <= exeResolve_i.outcome;
    end
    if (commitCti_i)
    begin
      update_o <= ctiq[head];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      updateEn_o <= 1'b0;
    end
    else
    begin
      updateEn_o <= commitCti_i;
      if (recoverFlag_i)
      begin
        // Commit-time flush empties the whole queue
        head  <= '0;
        tail  <= '0;
        count <= '0;
      end
      else
      begin
        if (commitCti_i)
        begin
          head <= head + 1'b1;
        end
        if (flagRecoverEX_i)
        begin
          tail  <= exeResolve_i.index + 1'b1;
          count <= {1'b0, keepDist} + 1'b1 - (CTIQ_TAG_WIDTH+1)'(commitCti_i);
        end
        else
        begin
          tail  <= tail + allocNum;
          count <= count + {1'b0, allocNum} - (CTIQ_TAG_WIDTH+1)'(commitCti_i);
        end
      end
    end
  end

endmodule

//--- source/FetchStage2.sv
module FetchStage2
  import fetchPkg::*;
(
  input  logic                              clk,
  input  logic                              rst_i,
  input  logic                              fs1Ready_i,
  input  logic                              stall_i,
  input  logic                              recoverFlag_i,
  input  logic [PC_WIDTH-1:0]               pc_i,
  input  logic [FETCH_WIDTH*INST_WIDTH-1:0] instructionBundle_i,
  input  slotPred_t [FETCH_WIDTH-1:0]       slotPred_i,
  input  logic [PC_WIDTH-1:0]               addrRAS_i,
  input  exeResolve_t                       exeResolve_i,
  input  logic                              ctrlVerified_i,
  input  logic                              flagRecoverEX_i,
  input  logic                              commitCti_i,
  output instPacket_t [FETCH_WIDTH-1:0]     instPacket_o,
  output logic [FETCH_WIDTH-1:0]            instValid_o,
  output idRedirect_t                       redirect_o,
  output ctiUpdate_t                        update_o,
  output logic                              updateEn_o,
  output logic                              fs2Ready_o,
  output logic                              ctiQueueFull_o
);

  logic [FETCH_WIDTH-1:0][INST_WIDTH-1:0]     slotInst;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]       slotPc;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]       decTarget;
  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]       pktTarget;
  logic [FETCH_WIDTH-1:0][CTIQ_TAG_WIDTH-1:0] ctiqTag;
  ctrlType_t [FETCH_WIDTH-1:0]                slotType;
  logic [FETCH_WIDTH-1:0]                     isCtrl;
  logic [FETCH_WIDTH-1:0]                     takenVec;
  logic [FETCH_WIDTH-1:0]                     branchNT;
  logic [FETCH_WIDTH-1:0]                     ctrlVector;
  logic [$clog2(FETCH_WIDTH)-1:0]             firstSlot;
  logic                                       takenFound;
  logic                                       queueFull;
  idRedirect_t                                redirectRaw;

  for (genvar k = 0; k < FETCH_WIDTH; k++)
  begin : gSlot
    // Slot 0 sits in the low word and is the oldest
    assign slotInst[k] = instructionBundle_i[k*INST_WIDTH +: INST_WIDTH];
    assign slotPc[k]   = pc_i + PC_WIDTH'(4 * k);

    PreDecode preDecode (
      .instruction_i (slotInst[k]),
      .pc_i          (slotPc[k]),
      .btbTarget_i   (slotPred_i[k].targetAddr),
      .isCtrl_o      (isCtrl[k]),
      .ctrlType_o    (slotType[k]),
      .targetAddr_o  (decTarget[k])
    );

    assign takenVec[k] = isCtrl[k] &
                         ((slotType[k] != CTRL_BR) | slotPred_i[k].prediction);
    assign branchNT[k] = isCtrl[k] & (slotType[k] == CTRL_BR) & ~slotPred_i[k].prediction;

    assign instPacket_o[k] = '{instruction: slotInst[k],
                               pc:          slotPc[k],
                               targetAddr:  pktTarget[k],
                               ctiqTag:     ctiqTag[k],
                               prediction:  slotPred_i[k].prediction};
  end

  CtrlQueue ctiQueue (
    .clk             (clk),
    .rst_i           (rst_i),
    .fs1Ready_i      (fs1Ready_i),
    .stall_i         (stall_i),
    .recoverFlag_i   (recoverFlag_i),
    .slotPc_i        (slotPc),
    .slotType_i      (slotType),
    .ctrlVector_i    (ctrlVector),
    .ctiqTag_o       (ctiqTag),
    .exeResolve_i    (exeResolve_i),
    .ctrlVerified_i  (ctrlVerified_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .commitCti_i     (commitCti_i),
    .update_o        (update_o),
    .updateEn_o      (updateEn_o),
    .full_o          (queueFull)
  );

  // Lowest taken slot wins, so scan from the youngest down
  always_comb
  begin
    takenFound = 1'b0;
    firstSlot  = '0;
    for (int k = FETCH_WIDTH - 1; k >= 0; k--)
    begin
      if (takenVec[k])
      begin
        takenFound = 1'b1;
        firstSlot  = ($clog2(FETCH_WIDTH))'(k);
      end
    end
  end

  always_comb
  begin
    instValid_o = '1;
    ctrlVector  = branchNT;
    pktTarget   = decTarget;
    redirectRaw = '0;
    if (takenFound)
    begin
      for (int k = 0; k < FETCH_WIDTH; k++)
      begin
        instValid_o[k] = (k <= firstSlot);
        ctrlVector[k]  = (k < firstSlot) ? branchNT[k] : (k == firstSlot);
      end
      redirectRaw.targetAddr = decTarget[firstSlot];
      redirectRaw.callPC     = slotPc[firstSlot];
      // BTB did not know this transfer
      if (!slotPred_i[firstSlot].btbHit)
      begin
        redirectRaw.flagRecover = 1'b1;
        if (slotType[firstSlot] == CTRL_RTR)
        begin
          redirectRaw.flagRtr    = 1'b1;
          redirectRaw.targetAddr = addrRAS_i;
          pktTarget[firstSlot]   = addrRAS_i;
        end
        if (slotType[firstSlot] == CTRL_CALL)
        begin
          redirectRaw.flagCall = 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    redirect_o             = redirectRaw;
    redirect_o.flagRecover = redirectRaw.flagRecover & ~stall_i & ~queueFull;
  end

  assign ctiQueueFull_o = queueFull;
  assign fs2Ready_o     = fs1Ready_i & ~queueFull;

endmodule

//--- tests/fetchStage2_assert.sv
module ctiQueueAssert
  import fetchPkg::*;
(
  input logic                    clk,
  input logic                    rst_i,
  input logic                    commitCti_i,
  input logic                    updateEn_i,
  input logic                    full_i,
  input logic [CTIQ_TAG_WIDTH:0] count_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // Registered update strobe trails commit by one cycle
  updateDelay: assert property (@(posedge clk) disable iff (rst_i)
    updateEn_i == $past(commitCti_i))
  else
  begin
    $error("updateEn does not follow the commit strobe by exactly one cycle");
    failCount++;
  end

  commitNotEmpty: assert property (@(posedge clk) disable iff (rst_i)
    commitCti_i |-> count_i != 0)
  else
  begin
    $error("commit arrived while the control queue was empty");
    failCount++;
  end

  countBound: assert property (@(posedge clk) disable iff (rst_i)
    count_i <= CTIQ_DEPTH)
  else
  begin
    $error("control queue count exceeds its depth");
    failCount++;
  end

  // Full once fewer than a bundle's worth of entries are free
  fullRule: assert property (@(posedge clk) disable iff (rst_i)
    full_i == ((CTIQ_DEPTH - int'(count_i)) < FETCH_WIDTH))
  else
  begin
    $error("full flag disagrees with the free entry count");
    failCount++;
  end

endmodule

bind CtrlQueue ctiQueueAssert ctiqAssert (
  .clk         (clk),
  .rst_i       (rst_i),
  .commitCti_i (commitCti_i),
  .updateEn_i  (updateEn_o),
  .full_i      (full_o),
  .count_i     (count)
);

//--- tests/tbFetchStage2.sv
module tbFetchStage2
  import fetchPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic                              clk;
  logic                              rst;
  logic                              fs1Ready;
  logic                              stall;
  logic                              recoverFlag;
  logic [PC_WIDTH-1:0]               pc;
  logic [FETCH_WIDTH*INST_WIDTH-1:0] bundle;
  slotPred_t [FETCH_WIDTH-1:0]       slotPred;
  logic [PC_WIDTH-1:0]               addrRAS;
  exeResolve_t                       exeResolve;
  logic                              ctrlVerified;
  logic                              flagRecoverEX;
  logic                              commitCti;
  instPacket_t [FETCH_WIDTH-1:0]     instPacket;
  logic [FETCH_WIDTH-1:0]            instValid;
  idRedirect_t                       redirect;
  ctiUpdate_t                        update;
  logic                              updateEn;
  logic                              fs2Ready;
  logic                              queueFull;

  // Shadow of the control-transfer queue
  ctiUpdate_t             shQueue [CTIQ_DEPTH];
  logic                   shResolved [CTIQ_DEPTH];
  int                     head;
  int                     tail;
  int                     count;
  logic                   expUpdEn;
  ctiUpdate_t             expUpdate;
  int                     curFirst;
  logic [FETCH_WIDTH-1:0] curMark;
  int                     curType [FETCH_WIDTH];
  integer                 seed;
  int                     mismatches;
  int                     timeouts;
  int                     assertFails;
  int                     commitPct;
  logic                   quiet;
  string                  phase;

  FetchStage2 FetchStage2_inst (
    .clk                 (clk),
    .rst_i               (rst),
    .fs1Ready_i          (fs1Ready),
    .stall_i             (stall),
    .recoverFlag_i       (recoverFlag),
    .pc_i                (pc),
    .instructionBundle_i (bundle),
    .slotPred_i          (slotPred),
    .addrRAS_i           (addrRAS),
    .exeResolve_i        (exeResolve),
    .ctrlVerified_i      (ctrlVerified),
    .flagRecoverEX_i     (flagRecoverEX),
    .commitCti_i         (commitCti),
    .instPacket_o        (instPacket),
    .instValid_o         (instValid),
    .redirect_o          (redirect),
    .update_o            (update),
    .updateEn_o          (updateEn),
    .fs2Ready_o          (fs2Ready),
    .ctiQueueFull_o      (queueFull)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic chance(input int percent);
    return ($unsigned($random(seed)) % 100) < percent;
  endfunction

  // Half control transfers, half ordinary opcodes
  function automatic logic [INST_WIDTH-1:0] randomInst();
    logic [5:0] opcode;
    int         pick;
    pick = $unsigned($random(seed)) % 10;
    case (pick)
      0:       opcode = OPC_J;
      1:       opcode = OPC_JAL;
      2, 3:    opcode = OPC_BR;
      4:       opcode = OPC_JR;
      default: opcode = 6'h10 + 6'(pick);
    endcase
    return {opcode, 26'($random(seed))};
  endfunction

  function automatic int ruleType(input logic [5:0] opcode);
    case (opcode)
      OPC_JR:  return CTRL_RTR;
      OPC_JAL: return CTRL_CALL;
      OPC_J:   return CTRL_JUMP;
      OPC_BR:  return CTRL_BR;
      default: return -1;
    endcase
  endfunction

  function automatic logic [PC_WIDTH-1:0] ruleTarget(input logic [INST_WIDTH-1:0] inst,
                                                     input logic [PC_WIDTH-1:0] slotPc,
                                                     input logic [PC_WIDTH-1:0] btbTarget);
    case (inst[31:26])
      OPC_BR:        return slotPc + 32'd4 + {{14{inst[15]}}, inst[15:0], 2'b00};
      OPC_JAL, OPC_J: return {slotPc[31:28], inst[25:0], 2'b00};
      default:       return btbTarget;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    assert (actVal === expVal)
    else
    begin
      $display("MISMATCH %s/%s expected %h actual %h", phase, name, expVal, actVal);
      mismatches++;
    end
  endtask

  task automatic driveInputs();
    int offset;
    pc = PC_WIDTH'($random(seed)) & ~PC_WIDTH'(3);
    for (int k = 0; k < FETCH_WIDTH; k++)
    begin
      bundle[k*INST_WIDTH +: INST_WIDTH] = randomInst();
      slotPred[k].btbHit                 = chance(50);
      slotPred[k].targetAddr             = PC_WIDTH'($random(seed)) & ~PC_WIDTH'(3);
      slotPred[k].prediction             = chance(50);
    end
    addrRAS     = PC_WIDTH'($random(seed)) & ~PC_WIDTH'(3);
    fs1Ready    = !quiet && chance(85);
    stall       = chance(10);
    recoverFlag = !quiet && chance(3);
    offset      = (count > 0) ? ($unsigned($random(seed)) % count) : 0;
    // Resolving the head often keeps commits flowing
    if (quiet || chance(50))
    begin
      offset = 0;
    end
    exeResolve.index      = CTIQ_TAG_WIDTH'(head + offset);
    exeResolve.targetAddr = PC_WIDTH'($random(seed));
    exeResolve.outcome    = chance(50);
    ctrlVerified          = (count > 0) && chance(quiet ? 100 : 50);
    flagRecoverEX         = !quiet && (count > 0) && chance(4);
    commitCti             = (count > 0) && shResolved[head] && chance(commitPct);
  endtask

  task automatic evalSlots();
    logic taken;
    curFirst = -1;
    curMark  = '0;
    for (int k = 0; k < FETCH_WIDTH; k++)
    begin
      curType[k] = ruleType(bundle[k*INST_WIDTH+26 +: 6]);
      taken      = (curType[k] >= 0) && ((curType[k] != CTRL_BR) || slotPred[k].prediction);
      if (curFirst < 0)
      begin
        curMark[k] = taken || ((curType[k] == CTRL_BR) && !slotPred[k].prediction);
        if (taken)
        begin
          curFirst = k;
        end
      end
    end
  endtask

  task automatic checkOutputs();
    int                     tagOffset;
    logic                   miss;
    logic                   expFull;
    logic [PC_WIDTH-1:0]    expTarget;
    logic [FETCH_WIDTH-1:0] expValid;
    expFull   = count > CTIQ_DEPTH - FETCH_WIDTH;
    expValid  = (curFirst < 0) ? '1 : FETCH_WIDTH'((1 << (curFirst + 1)) - 1);
    miss      = (curFirst >= 0) && !slotPred[curFirst].btbHit;
    tagOffset = 0;
    checkValue("valid", expValid, instValid);
    checkValue("full", expFull, queueFull);
    checkValue("fs2Ready", fs1Ready && !expFull, fs2Ready);
    for (int k = 0; k < FETCH_WIDTH; k++)
    begin
      if (expValid[k])
      begin
        checkValue($sformatf("slot%0d pc", k), pc + PC_WIDTH'(4 * k), instPacket[k].pc);
        checkValue($sformatf("slot%0d inst", k), bundle[k*INST_WIDTH +: INST_WIDTH],
                   instPacket[k].instruction);
        checkValue($sformatf("slot%0d pred", k), slotPred[k].prediction,
                   instPacket[k].prediction);
        if (curType[k] >= 0)
        begin
          expTarget = ruleTarget(bundle[k*INST_WIDTH +: INST_WIDTH], pc + PC_WIDTH'(4 * k),
                                 slotPred[k].targetAddr);
          if (miss && k == curFirst && curType[k] == CTRL_RTR)
          begin
            expTarget = addrRAS;
          end
          checkValue($sformatf("slot%0d target", k), expTarget, instPacket[k].targetAddr);
        end
      end
      if (curMark[k])
      begin
        checkValue($sformatf("slot%0d tag", k), (tail + tagOffset) % CTIQ_DEPTH,
                   instPacket[k].ctiqTag);
        tagOffset++;
      end
    end
    checkValue("redirect flagRecover", miss && !stall && !expFull, redirect.flagRecover);
    checkValue("redirect flagRtr", miss && curType[curFirst] == CTRL_RTR, redirect.flagRtr);
    checkValue("redirect flagCall", miss && curType[curFirst] == CTRL_CALL, redirect.flagCall);
    if (curFirst >= 0)
    begin
      expTarget = ruleTarget(bundle[curFirst*INST_WIDTH +: INST_WIDTH],
                             pc + PC_WIDTH'(4 * curFirst), slotPred[curFirst].targetAddr);
      if (miss && curType[curFirst] == CTRL_RTR)
      begin
        expTarget = addrRAS;
      end
      checkValue("redirect target", expTarget, redirect.targetAddr);
      if (miss && curType[curFirst] == CTRL_CALL)
      begin
        checkValue("redirect callPC", pc + PC_WIDTH'(4 * curFirst), redirect.callPC);
      end
    end
    checkValue("updateEn", expUpdEn, updateEn);
    if (expUpdEn)
    begin
      checkValue("update pc", expUpdate.pc, update.pc);
      checkValue("update target", expUpdate.targetAddr, update.targetAddr);
      checkValue("update type", expUpdate.ctrlType, update.ctrlType);
      checkValue("update dir", expUpdate.dir, update.dir);
    end
  endtask

  // Queue state after the coming clock edge
  task automatic advanceModel();
    logic alloc;
    int   resIdx;
    alloc    = fs1Ready && !stall && !(count > CTIQ_DEPTH - FETCH_WIDTH) && !recoverFlag &&
               !flagRecoverEX;
    resIdx   = exeResolve.index;
    expUpdEn = commitCti;
    if (commitCti)
    begin
      expUpdate = shQueue[head];
    end
    if (ctrlVerified)
    begin
      shQueue[resIdx].targetAddr = exeResolve.targetAddr;
      shQueue[resIdx].dir        = exeResolve.outcome;
      shResolved[resIdx]         = 1'b1;
    end
    if (recoverFlag)
    begin
      head  = 0;
      tail  = 0;
      count = 0;
    end
    else if (flagRecoverEX)
    begin
      count = ((resIdx - head) & (CTIQ_DEPTH - 1)) + 1 - int'(commitCti);
      tail  = (resIdx + 1) % CTIQ_DEPTH;
      head  = (head + int'(commitCti)) % CTIQ_DEPTH;
    end
    else
    begin
      for (int k = 0; k < FETCH_WIDTH; k++)
      begin
        if (alloc && curMark[k])
        begin
          shQueue[tail].pc       = pc + PC_WIDTH'(4 * k);
          shQueue[tail].ctrlType = ctrlType_t'(curType[k]);
          shResolved[tail]       = 1'b0;
          tail                   = (tail + 1) % CTIQ_DEPTH;
          count++;
        end
      end
      count = count - int'(commitCti);
      head  = (head + int'(commitCti)) % CTIQ_DEPTH;
    end
  endtask

  task automatic stepCycle();
    @(negedge clk);
    driveInputs();
    #1;
    evalSlots();
    checkOutputs();
    advanceModel();
  endtask

  initial
  begin
    int waited;
    seed          = 32'h03af761a;
    mismatches    = 0;
    timeouts      = 0;
    head          = 0;
    tail          = 0;
    count         = 0;
    expUpdEn      = 1'b0;
    quiet         = 1'b0;
    commitPct     = 0;
    phase         = "reset";
    rst           = 1'b1;
    fs1Ready      = 1'b0;
    stall         = 1'b0;
    recoverFlag   = 1'b0;
    pc            = '0;
    bundle        = '0;
    slotPred      = '0;
    addrRAS       = '0;
    exeResolve    = '0;
    ctrlVerified  = 1'b0;
    flagRecoverEX = 1'b0;
    commitCti     = 1'b0;
    for (int i = 0; i < 10; i++)
    begin
      @(negedge clk);
    end
    rst = 1'b0;
    // Alternate between filling the queue and draining it
    for (int cycle = 0; cycle < 600; cycle++)
    begin
      phase     = ((cycle / 150) % 2 == 0) ? "fill" : "commit";
      commitPct = (phase == "fill") ? 15 : 90;
      stepCycle();
    end
    phase     = "drain";
    quiet     = 1'b1;
    commitPct = 100;
    waited    = 0;
    while (count != 0 && waited < 100)
    begin
      stepCycle();
      waited++;
    end
    if (count != 0)
    begin
      $display("Timeout: the control queue did not drain through commits");
      timeouts++;
    end
    stepCycle();
    assertFails = FetchStage2_inst.ctiQueue.ctiqAssert.failCount;
    $display("Errors: mismatches %0d, assertion failures %0d, timeouts %0d",
             mismatches, assertFails, timeouts);
    if (mismatches + assertFails + timeouts == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
source/fetchPkg.sv
source/PreDecode.sv
source/CtrlQueue.sv
source/FetchStage2.sv
tests/fetchStage2_assert.sv
tests/tbFetchStage2.sv

//--- Bender.yml
package:
  name: fetch_stage2

sources:
  - source/fetchPkg.sv
  - source/PreDecode.sv
  - source/CtrlQueue.sv
  - source/FetchStage2.sv
  - target: test
    files:
      - tests/fetchStage2_assert.sv
      - tests/tbFetchStage2.sv
